// ==== link_state_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module link_state_tracker (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic i_load_init,
	input wire logic i_degrade,
	input wire logic i_ls_done,
	input wire logic i_repair_start,
	input wire logic i_repair_done,
	input wire logic i_finish_exit,
	input wire mbtrain_pkg::speed_t i_highest_speed,
	input wire mbtrain_pkg::lane_halves_t i_init_tx_lanes,
	input wire mbtrain_pkg::lane_halves_t i_init_rx_lanes,
	input wire mbtrain_pkg::lane_halves_t i_ls_tx_lanes,
	input wire mbtrain_pkg::lane_halves_t i_repair_rx_lanes,
	output mbtrain_pkg::speed_t o_speed,
	output mbtrain_pkg::lane_halves_t o_tx_lanes,
	output mbtrain_pkg::lane_halves_t o_rx_lanes,
	output logic o_coming_from_repair
);

	// repair already happened in mbinit, or was started during this training
	logic init_repair;
	logic train_repair;

	assign o_coming_from_repair = init_repair | train_repair;

	// the operating speed never steps below the lowest code
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_speed <= '0;
		end else if (i_load_init) begin
			o_speed <= i_highest_speed;
		end else if (i_degrade && (o_speed != '0)) begin
			o_speed <= o_speed - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_tx_lanes <= '0;
			o_rx_lanes <= '0;
		end else begin
			if (i_load_init) begin
				o_tx_lanes <= i_init_tx_lanes;
				o_rx_lanes <= i_init_rx_lanes;
			end
			// tx width is settled by the link speed point test
			if (i_ls_done)
				o_tx_lanes <= i_ls_tx_lanes;
			if (i_repair_done)
				o_rx_lanes <= i_repair_rx_lanes;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			init_repair <= 1'b0;
			train_repair <= 1'b0;
		end else if (i_finish_exit) begin
			init_repair <= 1'b0;
			train_repair <= 1'b0;
		end else begin
			if (i_load_init && !(&i_init_tx_lanes))
				init_repair <= 1'b1;
			if (i_repair_start)
				train_repair <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== mbtrain_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbtrain_consts.svh"

module mbtrain_checker #(
	parameter int MAX_SEQ = 24
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire mbtrain_pkg::step_vec_t i_step_en,
	input wire mbtrain_pkg::step_vec_t i_step_ack,
	input wire mbtrain_pkg::sb_substate_t i_sb_substate,
	input wire mbtrain_pkg::mux_sel_t i_mux_sel,
	input wire logic i_valtrain_test,
	input wire logic i_phyretrain_en,
	input wire logic i_mbtrain_ack,
	input wire mbtrain_pkg::speed_t i_speed,
	input wire mbtrain_pkg::lane_halves_t i_tx_lanes,
	input wire mbtrain_pkg::lane_halves_t i_rx_lanes,
	input wire logic i_coming_from_repair,
	input wire mbtrain_pkg::speed_t i_exp_speed,
	input wire mbtrain_pkg::lane_halves_t i_exp_tx,
	input wire mbtrain_pkg::lane_halves_t i_exp_rx,
	input wire logic i_exp_phy,
	input wire logic i_exp_cfr,
	input wire logic [4*MAX_SEQ-1:0] i_exp_seq,
	input int i_exp_len,
	output int o_errors,
	output int o_rows
);

	int cyc;
	int last_low;
	int vis [MAX_SEQ];
	int vis_len;
	mbtrain_pkg::step_vec_t prev_en;
	mbtrain_pkg::step_vec_t waiting;
	logic prev_ack;

	// pattern select of each substep in training order
	function automatic mbtrain_pkg::mux_sel_t table_mux(input int s);
		case (s)
			0, 1, 6, 8: table_mux = `MBT_MUX_VREF;
			2, 3: table_mux = `MBT_MUX_SELFCAL;
			4, 9: table_mux = `MBT_MUX_RXCAL;
			5, 7, 10: table_mux = `MBT_MUX_CENTER;
			11: table_mux = `MBT_MUX_LINKSPEED;
			default: table_mux = `MBT_MUX_REPAIR;
		endcase
	endfunction

	task automatic compare(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
			o_errors = o_errors + 1;
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc = 0;
			last_low = 0;
			vis_len = 0;
			prev_en = '0;
			waiting = '0;
			prev_ack = 1'b0;
			o_errors = 0;
			o_rows = 0;
		end else begin
			cyc = cyc + 1;
			for (int s = 0; s < `MBT_NUM_STEPS; s++) begin
				if (i_step_en[s] && !prev_en[s]) begin
					compare($sformatf("substate at step %0d", s), int'(i_sb_substate), s);
					compare($sformatf("mux at step %0d", s), int'(i_mux_sel), int'(table_mux(s)));
					compare($sformatf("valid test at step %0d", s), int'(i_valtrain_test),
						(s == 0 || s == 5 || s == 6) ? 1 : 0);
					if (vis_len < MAX_SEQ)
						vis[vis_len] = s;
					vis_len = vis_len + 1;
				end
				if (!i_step_en[s] && prev_en[s])
					waiting[s] = 1'b1;
				// ack low after en fell ends the exchange
				if (waiting[s] && !i_step_ack[s]) begin
					waiting[s] = 1'b0;
					last_low = cyc;
				end
			end
			if (i_mbtrain_ack && !prev_ack) begin
				// the ack register rose on the previous edge which is 2 cycles after the last ack low
				compare("ack latency", cyc - last_low, 3);
				compare("speed", int'(i_speed), int'(i_exp_speed));
				compare("tx lanes", int'(i_tx_lanes), int'(i_exp_tx));
				compare("rx lanes", int'(i_rx_lanes), int'(i_exp_rx));
				compare("phyretrain enable", int'(i_phyretrain_en), int'(i_exp_phy));
				compare("coming from repair", int'(i_coming_from_repair), int'(i_exp_cfr));
				compare("visited step count", vis_len, i_exp_len);
				for (int i = 0; i < i_exp_len && i < vis_len && i < MAX_SEQ; i++)
					compare($sformatf("visited step %0d", i), vis[i], int'(i_exp_seq[i*4 +: 4]));
				vis_len = 0;
				o_rows = o_rows + 1;
			end
			prev_en = i_step_en;
			prev_ack = i_mbtrain_ack;
		end
	end

endmodule

`default_nettype wire

// ==== mbtrain_consts.svh ====
`ifndef MBTRAIN_CONSTS_SVH
`define MBTRAIN_CONSTS_SVH

// number of mainband training substeps, valid vref through repair
`define MBT_NUM_STEPS 13

// field widths
`define MBT_SPEED_W 3
`define MBT_SB_W 4
`define MBT_MUX_W 3

// sideband substate sent while no substep is active
`define MBT_SB_IDLE 4'd0

// pattern mux select codes
// vref sweeps for valid and data lanes
`define MBT_MUX_VREF 3'd0
// self calibration and speed idle
`define MBT_MUX_SELFCAL 3'd1
// point test during link speed
`define MBT_MUX_LINKSPEED 3'd2
// lane repair exchange
`define MBT_MUX_REPAIR 3'd3
// eye center search
`define MBT_MUX_CENTER 3'd4
// rx clock cal and deskew
`define MBT_MUX_RXCAL 3'd5

`endif

// ==== mbtrain_pkg.sv ====
`default_nettype none

`include "mbtrain_consts.svh"

package mbtrain_pkg;

	// substeps in training order, the value is also the sideband substate
	typedef enum logic [$clog2(`MBT_NUM_STEPS)-1:0] {
		step_valid_vref = 0,
		step_data_vref = 1,
		step_speed_idle = 2,
		step_tx_selfcal = 3,
		step_rx_clk_cal = 4,
		step_val_train_center = 5,
		step_val_train_vref = 6,
		step_data_train_center1 = 7,
		step_data_train_vref = 8,
		step_rx_deskew = 9,
		step_data_train_center2 = 10,
		step_link_speed = 11,
		step_repair = 12
	} step_t;

	// one bit per substep, indexed by step_t
	typedef logic [`MBT_NUM_STEPS-1:0] step_vec_t;

	typedef logic [`MBT_SPEED_W-1:0] speed_t;
	typedef logic [`MBT_SB_W-1:0] sb_substate_t;
	typedef logic [`MBT_MUX_W-1:0] mux_sel_t;

	// bit 0 lanes 0..7 functional, bit 1 lanes 8..15 functional
	typedef logic [1:0] lane_halves_t;

	// resolved retrain state from phy retrain
	typedef enum logic [1:0] {
		full_train = 2'd0,
		from_selfcal = 2'd1,
		from_repair = 2'd2,
		degrade = 2'd3
	} retrain_state_t;

	typedef enum logic [1:0] {
		idle,
		run,
		finish
	} seq_state_t;

endpackage

`default_nettype wire

// ==== mbtrain_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbtrain_consts.svh"

module mbtrain_properties (
	input wire logic clk,
	input wire logic rst_n,
	input wire mbtrain_pkg::step_vec_t i_step_en,
	input wire logic i_mbtrain_ack
);

	// only one substep engine may be enabled at a time
	a_en_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(i_step_en))
		else $error("more than one substep enable is high");

	// training ack means no substep is still running
	a_ack_no_en: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_mbtrain_ack && (|i_step_en)))
		else $error("training ack is high while a substep enable is high");

	// first clock out of reset sees all enables low
	a_reset_en: assert property (@(posedge clk) $rose(rst_n) |-> (i_step_en == '0))
		else $error("substep enable is high right after reset");

endmodule

bind mbtrain_top mbtrain_properties u_props (
	.clk(clk),
	.rst_n(rst_n),
	.i_step_en(o_step_en),
	.i_mbtrain_ack(o_mbtrain_ack)
);

`default_nettype wire

// ==== mbtrain_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbtrain_consts.svh"

module mbtrain_sequencer (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic i_en,
	input wire mbtrain_pkg::retrain_state_t i_retrain_state,
	input wire mbtrain_pkg::step_vec_t i_step_done,
	input wire logic i_retrain_req,
	input wire logic i_error_req,
	input wire logic i_degrade_req,
	output mbtrain_pkg::step_vec_t o_start,
	output mbtrain_pkg::sb_substate_t o_sb_substate,
	output mbtrain_pkg::mux_sel_t o_mux_sel,
	output logic o_valtrain_test,
	output logic o_phyretrain_en,
	output logic o_mbtrain_ack,
	output logic o_load_init,
	output logic o_degrade,
	output logic o_ls_done,
	output logic o_repair_start,
	output logic o_repair_done,
	output logic o_finish_exit
);

	mbtrain_pkg::seq_state_t state;
	mbtrain_pkg::step_t cur_step;
	mbtrain_pkg::step_t next_step;
	logic launch;
	logic go_finish;
	logic retrain_fin;
	logic load_init_d;
	logic degrade_d;
	logic ls_done_d;
	logic repair_start_d;
	logic repair_done_d;
	logic finish_exit_d;

	function automatic mbtrain_pkg::mux_sel_t step_mux(input mbtrain_pkg::step_t s);
		case (s)
			mbtrain_pkg::step_valid_vref: step_mux = `MBT_MUX_VREF;
			mbtrain_pkg::step_data_vref: step_mux = `MBT_MUX_VREF;
			mbtrain_pkg::step_speed_idle: step_mux = `MBT_MUX_SELFCAL;
			mbtrain_pkg::step_tx_selfcal: step_mux = `MBT_MUX_SELFCAL;
			mbtrain_pkg::step_rx_clk_cal: step_mux = `MBT_MUX_RXCAL;
			mbtrain_pkg::step_val_train_center: step_mux = `MBT_MUX_CENTER;
			mbtrain_pkg::step_val_train_vref: step_mux = `MBT_MUX_VREF;
			mbtrain_pkg::step_data_train_center1: step_mux = `MBT_MUX_CENTER;
			mbtrain_pkg::step_data_train_vref: step_mux = `MBT_MUX_VREF;
			mbtrain_pkg::step_rx_deskew: step_mux = `MBT_MUX_RXCAL;
			mbtrain_pkg::step_data_train_center2: step_mux = `MBT_MUX_CENTER;
			mbtrain_pkg::step_link_speed: step_mux = `MBT_MUX_LINKSPEED;
			mbtrain_pkg::step_repair: step_mux = `MBT_MUX_REPAIR;
			default: step_mux = `MBT_MUX_VREF;
		endcase
	endfunction

	// next step decision, only the active cell's done bit matters
	always_comb begin
		launch = 1'b0;
		next_step = cur_step;
		go_finish = 1'b0;
		retrain_fin = 1'b0;
		load_init_d = 1'b0;
		degrade_d = 1'b0;
		ls_done_d = 1'b0;
		repair_start_d = 1'b0;
		repair_done_d = 1'b0;
		finish_exit_d = 1'b0;
		case (state)
			mbtrain_pkg::idle: begin
				if (i_en) begin
					launch = 1'b1;
					case (i_retrain_state)
						mbtrain_pkg::full_train: begin
							next_step = mbtrain_pkg::step_valid_vref;
							load_init_d = 1'b1;
						end
						mbtrain_pkg::from_selfcal: next_step = mbtrain_pkg::step_tx_selfcal;
						mbtrain_pkg::from_repair: begin
							next_step = mbtrain_pkg::step_repair;
							repair_start_d = 1'b1;
						end
						mbtrain_pkg::degrade: begin
							next_step = mbtrain_pkg::step_speed_idle;
							degrade_d = 1'b1;
						end
					endcase
				end
			end
			mbtrain_pkg::run: begin
				if (i_step_done[cur_step]) begin
					case (cur_step)
						mbtrain_pkg::step_link_speed: begin
							// requests are sampled in the done cycle
							if (i_retrain_req) begin
								go_finish = 1'b1;
								retrain_fin = 1'b1;
							end else begin
								ls_done_d = 1'b1;
								if (i_error_req && i_degrade_req) begin
									launch = 1'b1;
									next_step = mbtrain_pkg::step_speed_idle;
									degrade_d = 1'b1;
								end else if (i_error_req) begin
									launch = 1'b1;
									next_step = mbtrain_pkg::step_repair;
									repair_start_d = 1'b1;
								end else begin
									go_finish = 1'b1;
								end
							end
						end
						mbtrain_pkg::step_repair: begin
							launch = 1'b1;
							next_step = mbtrain_pkg::step_tx_selfcal;
							repair_done_d = 1'b1;
						end
						default: begin
							launch = 1'b1;
							next_step = mbtrain_pkg::step_t'(cur_step + 1'b1);
						end
					endcase
				end
			end
			mbtrain_pkg::finish: finish_exit_d = !i_en;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mbtrain_pkg::idle;
			cur_step <= mbtrain_pkg::step_valid_vref;
			o_start <= '0;
			o_sb_substate <= `MBT_SB_IDLE;
			o_mux_sel <= `MBT_MUX_VREF;
			o_valtrain_test <= 1'b0;
			o_phyretrain_en <= 1'b0;
			o_mbtrain_ack <= 1'b0;
			o_load_init <= 1'b0;
			o_degrade <= 1'b0;
			o_ls_done <= 1'b0;
			o_repair_start <= 1'b0;
			o_repair_done <= 1'b0;
			o_finish_exit <= 1'b0;
		end else begin
			o_start <= '0;
			o_load_init <= load_init_d;
			o_degrade <= degrade_d;
			o_ls_done <= ls_done_d;
			o_repair_start <= repair_start_d;
			o_repair_done <= repair_done_d;
			o_finish_exit <= finish_exit_d;
			// codes go out with the start pulse so they are stable when en rises
			if (launch) begin
				state <= mbtrain_pkg::run;
				cur_step <= next_step;
				o_start[next_step] <= 1'b1;
				o_sb_substate <= mbtrain_pkg::sb_substate_t'(next_step);
				o_mux_sel <= step_mux(next_step);
				o_valtrain_test <= next_step inside {mbtrain_pkg::step_valid_vref,
					mbtrain_pkg::step_val_train_center, mbtrain_pkg::step_val_train_vref};
			end else if (go_finish) begin
				state <= mbtrain_pkg::finish;
				o_sb_substate <= `MBT_SB_IDLE;
				o_phyretrain_en <= retrain_fin;
			end else if (state == mbtrain_pkg::finish) begin
				// ack holds until the caller drops enable
				o_mbtrain_ack <= i_en;
				if (finish_exit_d) begin
					state <= mbtrain_pkg::idle;
					o_phyretrain_en <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== mbtrain_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbtrain_consts.svh"

module mbtrain_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic i_en,
	input wire mbtrain_pkg::retrain_state_t i_retrain_state,
	input wire mbtrain_pkg::speed_t i_highest_speed,
	input wire mbtrain_pkg::lane_halves_t i_init_tx_lanes,
	input wire mbtrain_pkg::lane_halves_t i_init_rx_lanes,
	input wire mbtrain_pkg::lane_halves_t i_ls_tx_lanes,
	input wire mbtrain_pkg::lane_halves_t i_repair_rx_lanes,
	input wire mbtrain_pkg::step_vec_t i_step_ack,
	input wire logic i_retrain_req,
	input wire logic i_error_req,
	input wire logic i_degrade_req,
	output mbtrain_pkg::step_vec_t o_step_en,
	output mbtrain_pkg::sb_substate_t o_sb_substate,
	output mbtrain_pkg::mux_sel_t o_mux_sel,
	output logic o_valtrain_test,
	output logic o_phyretrain_en,
	output logic o_mbtrain_ack,
	output mbtrain_pkg::speed_t o_speed,
	output mbtrain_pkg::lane_halves_t o_tx_lanes,
	output mbtrain_pkg::lane_halves_t o_rx_lanes,
	output logic o_coming_from_repair
);

	mbtrain_pkg::step_vec_t start_vec;
	mbtrain_pkg::step_vec_t done_vec;
	logic load_init;
	logic degrade;
	logic ls_done;
	logic repair_start;
	logic repair_done;
	logic finish_exit;

	mbtrain_sequencer u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.i_en(i_en),
		.i_retrain_state(i_retrain_state),
		.i_step_done(done_vec),
		.i_retrain_req(i_retrain_req),
		.i_error_req(i_error_req),
		.i_degrade_req(i_degrade_req),
		.o_start(start_vec),
		.o_sb_substate(o_sb_substate),
		.o_mux_sel(o_mux_sel),
		.o_valtrain_test(o_valtrain_test),
		.o_phyretrain_en(o_phyretrain_en),
		.o_mbtrain_ack(o_mbtrain_ack),
		.o_load_init(load_init),
		.o_degrade(degrade),
		.o_ls_done(ls_done),
		.o_repair_start(repair_start),
		.o_repair_done(repair_done),
		.o_finish_exit(finish_exit)
	);

	// one handshake cell per substep engine
	for (genvar g = 0; g < `MBT_NUM_STEPS; g++) begin : g_step
		substep_handshake u_cell (
			.clk(clk),
			.rst_n(rst_n),
			.i_start(start_vec[g]),
			.i_ack(i_step_ack[g]),
			.o_en(o_step_en[g]),
			.o_done(done_vec[g])
		);
	end

	link_state_tracker u_track (
		.clk(clk),
		.rst_n(rst_n),
		.i_load_init(load_init),
		.i_degrade(degrade),
		.i_ls_done(ls_done),
		.i_repair_start(repair_start),
		.i_repair_done(repair_done),
		.i_finish_exit(finish_exit),
		.i_highest_speed(i_highest_speed),
		.i_init_tx_lanes(i_init_tx_lanes),
		.i_init_rx_lanes(i_init_rx_lanes),
		.i_ls_tx_lanes(i_ls_tx_lanes),
		.i_repair_rx_lanes(i_repair_rx_lanes),
		.o_speed(o_speed),
		.o_tx_lanes(o_tx_lanes),
		.o_rx_lanes(o_rx_lanes),
		.o_coming_from_repair(o_coming_from_repair)
	);

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
mbtrain_pkg.sv
substep_handshake.sv
mbtrain_sequencer.sv
link_state_tracker.sv
mbtrain_top.sv
mbtrain_properties.sv
mbtrain_checker.sv
tb_mbtrain.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the mbtrain testbench
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module tb_mbtrain -o sim_mbtrain

./obj_dir/sim_mbtrain | tee sim.log

if grep -q "^All checks passed$" sim.log; then
	exit 0
fi
exit 1

// ==== substep_handshake.sv ====
`timescale 1ns/100ps
`default_nettype none

module substep_handshake (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic i_start,
	input wire logic i_ack,
	output logic o_en,
	output logic o_done
);

	typedef enum logic [1:0] {
		ph_off,
		ph_ack_high,
		ph_ack_low
	} phase_t;

	phase_t phase;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= ph_off;
			o_en <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (phase)
				ph_off: begin
					if (i_start) begin
						o_en <= 1'b1;
						phase <= ph_ack_high;
					end
				end
				ph_ack_high: begin
					// engine finished, release en and wait for it to let go of ack
					if (i_ack) begin
						o_en <= 1'b0;
						phase <= ph_ack_low;
					end
				end
				ph_ack_low: begin
					if (!i_ack) begin
						o_done <= 1'b1;
						phase <= ph_off;
					end
				end
				default: phase <= ph_off;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb_mbtrain.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbtrain_consts.svh"

module tb_mbtrain;

	localparam int NUM_ROWS = 8;
	localparam int MAX_SEQ = 24;
	localparam int WATCHDOG_NS = NUM_ROWS * 20 * 16 * 10 + 1000;

	logic clk = 1'b0;
	logic rst_n;
	logic en;
	mbtrain_pkg::retrain_state_t retrain_state;
	mbtrain_pkg::speed_t highest_speed;
	mbtrain_pkg::lane_halves_t init_tx, init_rx, ls_tx, repair_rx;
	logic retrain_req, error_req, degrade_req;
	wire mbtrain_pkg::step_vec_t step_ack;
	mbtrain_pkg::step_vec_t step_en;
	mbtrain_pkg::sb_substate_t sb_substate;
	mbtrain_pkg::mux_sel_t mux_sel;
	logic valtrain_test, phyretrain_en, mbtrain_ack, coming_from_repair;
	mbtrain_pkg::speed_t speed;
	mbtrain_pkg::lane_halves_t tx_lanes, rx_lanes;

	// expected values of the row being run
	mbtrain_pkg::speed_t exp_speed;
	mbtrain_pkg::lane_halves_t exp_tx, exp_rx;
	logic exp_phy, exp_cfr;
	logic [4*MAX_SEQ-1:0] exp_seq;
	int exp_len;
	int chk_errors, chk_rows, tb_errors;
	logic ls_seen;

	// scenario table
	mbtrain_pkg::retrain_state_t row_state [NUM_ROWS];
	mbtrain_pkg::speed_t row_hs [NUM_ROWS];
	mbtrain_pkg::lane_halves_t row_itx [NUM_ROWS], row_irx [NUM_ROWS];
	mbtrain_pkg::lane_halves_t row_lstx [NUM_ROWS], row_reprx [NUM_ROWS];
	logic row_ret [NUM_ROWS], row_err [NUM_ROWS], row_deg [NUM_ROWS];
	mbtrain_pkg::speed_t row_espeed [NUM_ROWS];
	mbtrain_pkg::lane_halves_t row_etx [NUM_ROWS], row_erx [NUM_ROWS];
	logic row_ephy [NUM_ROWS], row_ecfr [NUM_ROWS];
	logic [4*MAX_SEQ-1:0] row_seq [NUM_ROWS];
	int row_len [NUM_ROWS];
	int n_rows;
	logic [4*MAX_SEQ-1:0] build_seq;
	int build_len;

	always #5 clk = ~clk;

	mbtrain_top i_dut (
		.clk(clk), .rst_n(rst_n), .i_en(en), .i_retrain_state(retrain_state),
		.i_highest_speed(highest_speed), .i_init_tx_lanes(init_tx), .i_init_rx_lanes(init_rx),
		.i_ls_tx_lanes(ls_tx), .i_repair_rx_lanes(repair_rx), .i_step_ack(step_ack),
		.i_retrain_req(retrain_req), .i_error_req(error_req), .i_degrade_req(degrade_req),
		.o_step_en(step_en), .o_sb_substate(sb_substate), .o_mux_sel(mux_sel),
		.o_valtrain_test(valtrain_test), .o_phyretrain_en(phyretrain_en),
		.o_mbtrain_ack(mbtrain_ack), .o_speed(speed), .o_tx_lanes(tx_lanes),
		.o_rx_lanes(rx_lanes), .o_coming_from_repair(coming_from_repair)
	);

	mbtrain_checker #(.MAX_SEQ(MAX_SEQ)) u_chk (
		.clk(clk), .rst_n(rst_n), .i_step_en(step_en), .i_step_ack(step_ack),
		.i_sb_substate(sb_substate), .i_mux_sel(mux_sel), .i_valtrain_test(valtrain_test),
		.i_phyretrain_en(phyretrain_en), .i_mbtrain_ack(mbtrain_ack), .i_speed(speed),
		.i_tx_lanes(tx_lanes), .i_rx_lanes(rx_lanes),
		.i_coming_from_repair(coming_from_repair), .i_exp_speed(exp_speed),
		.i_exp_tx(exp_tx), .i_exp_rx(exp_rx), .i_exp_phy(exp_phy), .i_exp_cfr(exp_cfr),
		.i_exp_seq(exp_seq), .i_exp_len(exp_len), .o_errors(chk_errors), .o_rows(chk_rows)
	);

	// substep engine models raise ack 1..6 cycles after en rises and drop it 1..4 after en falls
	for (genvar g = 0; g < `MBT_NUM_STEPS; g++) begin : g_resp
		logic ack_q;
		logic prev_en;
		int cnt;
		assign step_ack[g] = ack_q;
		always @(negedge clk or negedge rst_n) begin
			if (!rst_n) begin
				ack_q <= 1'b0;
				prev_en = 1'b0;
				cnt = 0;
			end else begin
				if (step_en[g] && !prev_en)
					cnt = 1 + int'($urandom % 6);
				else if (!step_en[g] && prev_en)
					cnt = 1 + int'($urandom % 4);
				if (cnt > 0) begin
					cnt = cnt - 1;
					if (cnt == 0)
						ack_q <= step_en[g];
				end
				prev_en = step_en[g];
			end
		end
	end

	task automatic seq_span(input int first, input int last);
		for (int i = first; i <= last; i++) begin
			build_seq[build_len*4 +: 4] = 4'(i);
			build_len = build_len + 1;
		end
	endtask

	task automatic add_row(input mbtrain_pkg::retrain_state_t st, input int hs,
		input int itx, input int irx, input int lstx, input int reprx,
		input logic ret, input logic err, input logic deg,
		input int espeed, input int etx, input int erx, input logic ephy, input logic ecfr);
		row_state[n_rows] = st;
		row_hs[n_rows] = 3'(hs);
		row_itx[n_rows] = 2'(itx);
		row_irx[n_rows] = 2'(irx);
		row_lstx[n_rows] = 2'(lstx);
		row_reprx[n_rows] = 2'(reprx);
		row_ret[n_rows] = ret;
		row_err[n_rows] = err;
		row_deg[n_rows] = deg;
		row_espeed[n_rows] = 3'(espeed);
		row_etx[n_rows] = 2'(etx);
		row_erx[n_rows] = 2'(erx);
		row_ephy[n_rows] = ephy;
		row_ecfr[n_rows] = ecfr;
		row_seq[n_rows] = build_seq;
		row_len[n_rows] = build_len;
		n_rows = n_rows + 1;
		build_seq = '0;
		build_len = 0;
	endtask

	task automatic build_table();
		// plain full train
		seq_span(0, 11);
		add_row(mbtrain_pkg::full_train, 5, 3, 3, 3, 3, 0, 0, 0, 5, 3, 3, 0, 0);
		// error and degrade at link speed drop one speed step
		seq_span(0, 11);
		seq_span(2, 11);
		add_row(mbtrain_pkg::full_train, 4, 3, 3, 1, 3, 0, 1, 1, 3, 1, 3, 0, 0);
		// degrade at the lowest speed holds it there
		seq_span(0, 11);
		seq_span(2, 11);
		add_row(mbtrain_pkg::full_train, 0, 3, 2, 3, 3, 0, 1, 1, 0, 3, 2, 0, 0);
		seq_span(2, 11);
		add_row(mbtrain_pkg::degrade, 7, 3, 3, 2, 3, 0, 0, 0, 0, 2, 2, 0, 0);
		// error alone goes through repair
		seq_span(0, 12);
		seq_span(3, 11);
		add_row(mbtrain_pkg::full_train, 2, 3, 3, 3, 1, 0, 1, 0, 2, 3, 1, 0, 1);
		// retrain request with an init tx half missing
		seq_span(0, 11);
		add_row(mbtrain_pkg::full_train, 6, 2, 3, 3, 3, 1, 0, 0, 6, 2, 3, 1, 1);
		seq_span(3, 11);
		add_row(mbtrain_pkg::from_selfcal, 1, 3, 3, 1, 3, 0, 0, 0, 6, 1, 3, 0, 0);
		seq_span(12, 12);
		seq_span(3, 11);
		add_row(mbtrain_pkg::from_repair, 1, 3, 3, 3, 2, 0, 0, 0, 6, 3, 2, 0, 1);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: training did not complete before the watchdog expired");
		$display("Checks failed");
		$finish;
	end

	initial begin
		void'($urandom(32676));
		rst_n = 1'b0;
		en = 1'b0;
		retrain_state = mbtrain_pkg::full_train;
		highest_speed = '0;
		init_tx = '0;
		init_rx = '0;
		ls_tx = '0;
		repair_rx = '0;
		retrain_req = 1'b0;
		error_req = 1'b0;
		degrade_req = 1'b0;
		exp_speed = '0;
		exp_tx = '0;
		exp_rx = '0;
		exp_phy = 1'b0;
		exp_cfr = 1'b0;
		exp_seq = '0;
		exp_len = 0;
		tb_errors = 0;
		n_rows = 0;
		build_seq = '0;
		build_len = 0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			@(negedge clk);
			retrain_state = row_state[r];
			highest_speed = row_hs[r];
			init_tx = row_itx[r];
			init_rx = row_irx[r];
			ls_tx = row_lstx[r];
			repair_rx = row_reprx[r];
			retrain_req = row_ret[r];
			error_req = row_err[r];
			degrade_req = row_deg[r];
			exp_speed = row_espeed[r];
			exp_tx = row_etx[r];
			exp_rx = row_erx[r];
			exp_phy = row_ephy[r];
			exp_cfr = row_ecfr[r];
			exp_seq = row_seq[r];
			exp_len = row_len[r];
			ls_seen = 1'b0;
			en = 1'b1;
			while (!mbtrain_ack) begin
				@(negedge clk);
				// requests only apply to the first link speed visit
				if (sb_substate == 4'd11) begin
					ls_seen = 1'b1;
				end else if (ls_seen) begin
					retrain_req = 1'b0;
					error_req = 1'b0;
					degrade_req = 1'b0;
				end
			end
			@(negedge clk);
			en = 1'b0;
			while (mbtrain_ack)
				@(negedge clk);
		end
		repeat (2) @(negedge clk);
		if (chk_rows != NUM_ROWS) begin
			$display("Only %0d of %0d training runs reached the ack check", chk_rows, NUM_ROWS);
			tb_errors = tb_errors + 1;
		end
		$display("checker errors: %0d, testbench errors: %0d, runs checked: %0d",
			chk_errors, tb_errors, chk_rows);
		if (chk_errors == 0 && tb_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
